//--- include/exec_settings.svh
`ifndef EXEC_SETTINGS_SVH
`define EXEC_SETTINGS_SVH

// Execution lanes behind the bus port
`define NUM_LANES 4

// Operand, result and bus width
`define DATA_WIDTH 32

`endif

//--- design/dpCluster_pkg.sv
`default_nettype none
`include "exec_settings.svh"

package dpCluster_pkg;

    typedef logic [`DATA_WIDTH-1:0]        word_t;      // Operand, result or instruction
    typedef logic [3:0]                    nzcv_t;      // N at the top
    typedef logic [3:0]                    cond_t;
    typedef logic [1:0]                    instClass_t;
    typedef logic [$clog2(`NUM_LANES)-1:0] laneIdx_t;
    typedef logic [15:0]                   status_t;

    localparam instClass_t CLASS_DP     = 2'd0;
    localparam instClass_t CLASS_MEM    = 2'd1;
    localparam instClass_t CLASS_BRANCH = 2'd2;
    localparam instClass_t CLASS_FLOAT  = 2'd3;

    // ARM data-processing opcodes
    typedef enum logic [3:0] {
        ALU_AND, ALU_EOR, ALU_SUB, ALU_RSB,
        ALU_ADD, ALU_ADC, ALU_SBC, ALU_RSC,
        ALU_TST, ALU_TEQ, ALU_CMP, ALU_CMN,
        ALU_ORR, ALU_MOV, ALU_BIC, ALU_MVN
    } aluOp_t;

    typedef enum logic {
        IDLE,
        ACK
    } busState_t;

    // Logical group, no adder involved
    function automatic logic isLogicOp(aluOp_t op);
        return op inside {ALU_AND, ALU_EOR, ALU_TST, ALU_TEQ,
                          ALU_ORR, ALU_MOV, ALU_BIC, ALU_MVN};
    endfunction

endpackage

`default_nettype wire

//--- design/controlUnit.sv
`default_nettype none

module controlUnit import dpCluster_pkg::*; (
    input  word_t      instr,
    output nzcv_t      flagW,
    output logic       pcs,
    output logic       regW,
    output logic       noWrite,
    output logic       aluSrc,
    output aluOp_t     aluCtl,
    output instClass_t instClass
);

    logic [1:0] op;
    logic [5:0] funct;
    logic [3:0] rd;
    logic       branch;
    logic       dpOp;

    assign op        = instr[27:26];
    assign funct     = instr[25:20];
    assign rd        = instr[15:12];
    assign instClass = instClass_t'(op);

    ////////////////////////////////////////////////////////////////////////////
    // Main decoder
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        branch = 1'b0;
        regW   = 1'b0;
        aluSrc = 1'b0;
        dpOp   = 1'b0;
        case (op)
            2'b00: begin
                aluSrc = funct[5];
                if (!funct[5] && instr[7:4] == 4'b1001 && instr[24:21] == 4'b0000) begin
                    regW = 1'b0;    // MUL encoding, illegal here
                end else begin
                    regW = 1'b1;
                    dpOp = 1'b1;
                end
            end
            2'b01: begin
                aluSrc = ~funct[5];
                // LDR writes back, STR and the DIV encoding do not
                regW = funct[0] && !(funct == 6'b111111 && instr[7:4] == 4'b1111);
            end
            2'b10: begin
                branch = 1'b1;
                aluSrc = 1'b1;
            end
            default: aluSrc = 1'b0;    // Float
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // ALU decoder
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        aluCtl  = ALU_ADD;
        flagW   = 4'b0000;
        noWrite = 1'b0;
        if (dpOp) begin
            aluCtl  = aluOp_t'(funct[4:1]);
            noWrite = funct[4:3] == 2'b10;    // TST TEQ CMP CMN
            if (funct[0]) begin
                flagW = isLogicOp(aluOp_t'(funct[4:1])) ? 4'b1110 : 4'b1111;
            end
        end else if (op == 2'b01) begin
            aluCtl = funct[3] ? ALU_ADD : ALU_SUB;    // U bit
        end
    end

    assign pcs = branch || (rd == 4'd15 && regW);

endmodule

`default_nettype wire

//--- design/aluCore.sv
`default_nettype none
`include "exec_settings.svh"

module aluCore import dpCluster_pkg::*; (
    input  word_t  a,
    input  word_t  b,
    input  aluOp_t op,
    input  logic   cIn,
    output word_t  y,
    output nzcv_t  flags
);

    word_t              addX;
    word_t              addY;
    logic               addC;
    logic [`DATA_WIDTH:0] sum;
    logic               overflow;
    logic               logicOp;

    // Subtraction as x + ~y + 1, carry out means no borrow
    always_comb begin
        addX = a;
        addY = b;
        addC = 1'b0;
        case (op)
            ALU_SUB, ALU_CMP: begin
                addY = ~b;
                addC = 1'b1;
            end
            ALU_RSB: begin
                addX = b;
                addY = ~a;
                addC = 1'b1;
            end
            ALU_ADC: addC = cIn;
            ALU_SBC: begin
                addY = ~b;
                addC = cIn;
            end
            ALU_RSC: begin
                addX = b;
                addY = ~a;
                addC = cIn;
            end
            default: addC = 1'b0;    // ADD CMN
        endcase
    end

    assign sum      = {1'b0, addX} + {1'b0, addY} + {{`DATA_WIDTH{1'b0}}, addC};
    assign overflow = (addX[`DATA_WIDTH-1] == addY[`DATA_WIDTH-1]) &&
                      (sum[`DATA_WIDTH-1] != addX[`DATA_WIDTH-1]);
    assign logicOp  = isLogicOp(op);

    always_comb begin
        case (op)
            ALU_AND, ALU_TST: y = a & b;
            ALU_EOR, ALU_TEQ: y = a ^ b;
            ALU_ORR:          y = a | b;
            ALU_MOV:          y = b;
            ALU_BIC:          y = a & ~b;
            ALU_MVN:          y = ~b;
            default:          y = sum[`DATA_WIDTH-1:0];
        endcase
    end

    // Logical ops keep C, V is never enabled for them
    assign flags = {y[`DATA_WIDTH-1], y == '0,
                    logicOp ? cIn : sum[`DATA_WIDTH],
                    logicOp ? 1'b0 : overflow};

endmodule

`default_nettype wire

//--- design/execLane.sv
`default_nettype none
`include "exec_settings.svh"

module execLane import dpCluster_pkg::*; (
    input  logic    clk,
    input  logic    rstN,
    input  logic    issue,
    input  word_t   instr,
    input  word_t   opA,
    input  word_t   opB,
    output logic    resValid,
    output word_t   result,
    output status_t status
);

    nzcv_t      flags;
    nzcv_t      flagW;
    nzcv_t      aluFlags;
    nzcv_t      flagMask;
    nzcv_t      nextFlags;
    logic       n;
    logic       z;
    logic       c;
    logic       v;
    logic       pcs;
    logic       regW;
    logic       noWrite;
    logic       aluSrc;
    aluOp_t     aluCtl;
    instClass_t instClass;
    cond_t      cond;
    logic       condPass;
    logic       doExec;
    logic       doWrite;
    word_t      immVal;
    word_t      operand2;
    word_t      aluY;
    word_t      nextResult;
    logic [2*`DATA_WIDTH-1:0] immRot;

    controlUnit uControlUnit (
        .instr     (instr),
        .flagW     (flagW),
        .pcs       (pcs),
        .regW      (regW),
        .noWrite   (noWrite),
        .aluSrc    (aluSrc),
        .aluCtl    (aluCtl),
        .instClass (instClass)
    );

    aluCore uAluCore (
        .a     (opA),
        .b     (operand2),
        .op    (aluCtl),
        .cIn   (c),
        .y     (aluY),
        .flags (aluFlags)
    );

    assign {n, z, c, v} = flags;
    assign cond = instr[31:28];

    always_comb begin
        case (cond)
            4'h0:    condPass = z;
            4'h1:    condPass = !z;
            4'h2:    condPass = c;
            4'h3:    condPass = !c;
            4'h4:    condPass = n;
            4'h5:    condPass = !n;
            4'h6:    condPass = v;
            4'h7:    condPass = !v;
            4'h8:    condPass = c && !z;
            4'h9:    condPass = !c || z;
            4'hA:    condPass = n == v;
            4'hB:    condPass = n != v;
            4'hC:    condPass = !z && (n == v);
            4'hD:    condPass = z || (n != v);
            default: condPass = 1'b1;    // AL and 1111
        endcase
    end

    // imm8 rotated right by twice the rotate field
    assign immRot   = {2{word_t'(instr[7:0])}} >> {instr[11:8], 1'b0};
    assign immVal   = immRot[`DATA_WIDTH-1:0];
    assign operand2 = aluSrc ? immVal : opB;

    // regW drops the MUL encoding out of the DP class
    assign doExec     = condPass && instClass == CLASS_DP && regW;
    assign doWrite    = doExec && !noWrite;
    assign flagMask   = doExec ? flagW : 4'b0000;
    assign nextFlags  = (flags & ~flagMask) | (aluFlags & flagMask);
    assign nextResult = doWrite ? aluY : result;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            resValid <= 1'b0;
            flags    <= '0;
            result   <= '0;
        end else begin
            resValid <= issue;
            if (issue) begin
                flags  <= nextFlags;
                result <= nextResult;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            status <= {nextResult == '0, doExec, instr[15:12], instClass, nextFlags,
                       flagMask != 4'b0000, pcs, doWrite, 1'b1};
        end
    end

endmodule

`default_nettype wire

//--- design/issueDispatcher.sv
`default_nettype none
`include "exec_settings.svh"

module issueDispatcher import dpCluster_pkg::*; (
    input  logic                  clk,
    input  logic                  rstN,
    input  logic                  wbCyc,
    input  logic                  wbStb,
    input  logic                  wbWe,
    input  logic [3:0]            wbAdr,
    input  word_t                 wbDatW,
    output logic                  wbAck,
    output word_t                 wbDatR,
    output logic [`NUM_LANES-1:0] issue,
    output word_t                 instr,
    output word_t                 opA,
    output word_t                 opB,
    output laneIdx_t              rdLane,
    output logic                  rdStatus,
    output logic                  clrDone,
    input  word_t                 rdData
);

    localparam logic [`NUM_LANES-1:0] LANE0 = 1;

    busState_t state;
    logic      request;
    logic      isInstr;
    laneIdx_t  wrLane;

    // Address decode
    assign request  = state == IDLE && wbCyc && wbStb;
    assign isInstr  = wbAdr >= 4'd2 && wbAdr <= 4'd5;
    assign wrLane   = laneIdx_t'(wbAdr - 4'd2);
    assign rdLane   = laneIdx_t'(wbAdr[1:0]);
    assign rdStatus = wbAdr[2];
    assign clrDone  = request && !wbWe && wbAdr[3:2] == 2'b11;

    ////////////////////////////////////////////////////////////////////////////
    // Bus FSM, one ack per request
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rstN) begin
            state <= IDLE;
            wbAck <= 1'b0;
            issue <= '0;
        end else begin
            wbAck <= 1'b0;
            issue <= '0;
            case (state)
                IDLE: begin
                    if (request) begin
                        state <= ACK;
                        wbAck <= 1'b1;
                        if (wbWe && isInstr) begin
                            issue <= LANE0 << wrLane;    // Lines up with ack
                        end
                    end
                end
                ACK: state <= IDLE;    // Stb still high from the taken request
            endcase
        end
    end

    // Operands, instruction and read data
    always_ff @(posedge clk) begin
        if (request && wbWe) begin
            if (wbAdr == 4'd0) begin
                opA <= wbDatW;
            end
            if (wbAdr == 4'd1) begin
                opB <= wbDatW;
            end
            if (isInstr) begin
                instr <= wbDatW;
            end
        end
        if (request && !wbWe) begin
            wbDatR <= wbAdr[3] ? rdData : '0;
        end
    end

endmodule

`default_nettype wire

//--- design/resultCollector.sv
`default_nettype none
`include "exec_settings.svh"

module resultCollector import dpCluster_pkg::*; (
    input  logic                                   clk,
    input  logic                                   rstN,
    input  logic [`NUM_LANES-1:0]                  resValid,
    input  logic [`NUM_LANES*`DATA_WIDTH-1:0]      result,
    input  logic [`NUM_LANES*$bits(status_t)-1:0]  status,
    input  laneIdx_t                               rdLane,
    input  logic                                   rdStatus,
    input  logic                                   clrDone,
    output word_t                                  rdData
);

    localparam int SW = $bits(status_t);

    word_t   resReg  [`NUM_LANES];
    status_t statReg [`NUM_LANES];
    word_t   selRes;
    status_t selStat;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < `NUM_LANES; i++) begin
                resReg[i]  <= '0;
                statReg[i] <= '0;
            end
        end else begin
            for (int i = 0; i < `NUM_LANES; i++) begin
                if (resValid[i]) begin
                    resReg[i]  <= result[i*`DATA_WIDTH +: `DATA_WIDTH];
                    statReg[i] <= status[i*SW +: SW];    // Lane reports done set
                end
                if (clrDone && rdLane == laneIdx_t'(i)) begin
                    statReg[i][0] <= 1'b0;
                end
            end
        end
    end

    // Bypass a lane finishing in the read cycle
    always_comb begin
        if (resValid[rdLane]) begin
            selRes  = result[rdLane*`DATA_WIDTH +: `DATA_WIDTH];
            selStat = status[rdLane*SW +: SW];
        end else begin
            selRes  = resReg[rdLane];
            selStat = statReg[rdLane];
        end
        rdData = rdStatus ? word_t'(selStat) : selRes;
    end

endmodule

`default_nettype wire

//--- design/dpCluster.sv
`default_nettype none
`include "exec_settings.svh"

module dpCluster import dpCluster_pkg::*; (
    input  logic       clk,
    input  logic       rstN,
    input  logic       wbCyc,
    input  logic       wbStb,
    input  logic       wbWe,
    input  logic [3:0] wbAdr,
    input  word_t      wbDatW,
    output word_t      wbDatR,
    output logic       wbAck
);

    localparam int SW = $bits(status_t);

    logic [`NUM_LANES-1:0]             issue;
    logic [`NUM_LANES-1:0]             resValid;
    word_t                             instr;
    word_t                             opA;
    word_t                             opB;
    logic [`NUM_LANES*`DATA_WIDTH-1:0] laneResult;
    logic [`NUM_LANES*SW-1:0]          laneStatus;
    laneIdx_t                          rdLane;
    logic                              rdStatus;
    logic                              clrDone;
    word_t                             rdData;

    issueDispatcher uDispatcher (
        .clk      (clk),
        .rstN     (rstN),
        .wbCyc    (wbCyc),
        .wbStb    (wbStb),
        .wbWe     (wbWe),
        .wbAdr    (wbAdr),
        .wbDatW   (wbDatW),
        .wbAck    (wbAck),
        .wbDatR   (wbDatR),
        .issue    (issue),
        .instr    (instr),
        .opA      (opA),
        .opB      (opB),
        .rdLane   (rdLane),
        .rdStatus (rdStatus),
        .clrDone  (clrDone),
        .rdData   (rdData)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Lanes share instr and operands, one issue line each
    ////////////////////////////////////////////////////////////////////////////
    for (genvar i = 0; i < `NUM_LANES; i++) begin : gLane
        execLane uLane (
            .clk      (clk),
            .rstN     (rstN),
            .issue    (issue[i]),
            .instr    (instr),
            .opA      (opA),
            .opB      (opB),
            .resValid (resValid[i]),
            .result   (laneResult[i*`DATA_WIDTH +: `DATA_WIDTH]),
            .status   (laneStatus[i*SW +: SW])
        );
    end

    resultCollector uCollector (
        .clk      (clk),
        .rstN     (rstN),
        .resValid (resValid),
        .result   (laneResult),
        .status   (laneStatus),
        .rdLane   (rdLane),
        .rdStatus (rdStatus),
        .clrDone  (clrDone),
        .rdData   (rdData)
    );

endmodule

`default_nettype wire

//--- testbench/clockGen.sv
`default_nettype none

module clockGen #(
    parameter int PERIOD = 100
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    always #(PERIOD / 2) clk = ~clk;    // Free running

endmodule

`default_nettype wire

//--- testbench/dpCluster_sva.sv
`default_nettype none
`include "exec_settings.svh"

module dpCluster_sva (
    input logic                  clk,
    input logic                  rstN,
    input logic                  wbAck,
    input logic [`NUM_LANES-1:0] issue
);

    // One ack per request, never two in a row
    ackSingle: assert property (@(posedge clk) disable iff (!rstN) wbAck |=> !wbAck)
        else $error("wbAck stayed high for two cycles");

    issueNeedsAck: assert property (@(posedge clk) disable iff (!rstN) |issue |-> wbAck)
        else $error("lane issue pulse without wbAck");

    issueOneHot: assert property (@(posedge clk) disable iff (!rstN) $onehot0(issue))
        else $error("more than one lane issued in the same cycle");    // Shared instr bus

endmodule

bind dpCluster dpCluster_sva uSva (
    .clk   (clk),
    .rstN  (rstN),
    .wbAck (wbAck),
    .issue (issue)
);

`default_nettype wire

//--- testbench/dpCluster_tb.sv
`default_nettype none
`include "exec_settings.svh"

module dpCluster_tb import dpCluster_pkg::*; ();

    localparam int PERIOD        = 100;
    localparam int ACK_LIMIT     = 16;
    localparam int BUS_OPS       = 600;    // About 560 transfers over all tests
    localparam int CYCLES_PER_OP = 4;

    logic       clk;
    logic       rstN;
    logic       wbCyc;
    logic       wbStb;
    logic       wbWe;
    logic [3:0] wbAdr;
    word_t      wbDatW;
    word_t      wbDatR;
    logic       wbAck;

    // Reference state per lane
    word_t curA;
    word_t curB;
    word_t modelRes [`NUM_LANES];
    nzcv_t modelFlg [`NUM_LANES];
    word_t expStat  [`NUM_LANES];

    clockGen #(.PERIOD(PERIOD)) uClock (.clk(clk));

    dpCluster i_dpCluster (
        .clk    (clk),
        .rstN   (rstN),
        .wbCyc  (wbCyc),
        .wbStb  (wbStb),
        .wbWe   (wbWe),
        .wbAdr  (wbAdr),
        .wbDatW (wbDatW),
        .wbDatR (wbDatR),
        .wbAck  (wbAck)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////////////////////
    function automatic logic condHolds(input cond_t cond, input nzcv_t f);
        logic n;
        logic z;
        logic c;
        logic v;
        {n, z, c, v} = f;
        case (cond)
            4'h0:    return z;                      // EQ
            4'h1:    return !z;
            4'h2:    return c;                      // CS
            4'h3:    return !c;
            4'h4:    return n;                      // MI
            4'h5:    return !n;
            4'h6:    return v;                      // VS
            4'h7:    return !v;
            4'h8:    return c && !z;                // HI
            4'h9:    return !c || z;
            4'hA:    return n == v;                 // GE
            4'hB:    return n != v;
            4'hC:    return !z && n == v;           // GT
            4'hD:    return z || n != v;
            default: return 1'b1;
        endcase
    endfunction

    function automatic word_t expandImm(input logic [11:0] field);
        word_t imm;
        int    sh;
        imm = word_t'(field[7:0]);
        sh  = 2 * int'(field[11:8]);
        return (imm >> sh) | (imm << (`DATA_WIDTH - sh));
    endfunction

    function automatic word_t dpInstr(input cond_t cond, input aluOp_t op, input logic s,
                                      input logic imm, input logic [3:0] rd,
                                      input logic [11:0] op2);
        return {cond, 2'b00, imm, op, s, 4'd1, rd, op2};
    endfunction

    task automatic applyModel(input int lane, input word_t ins);
        logic [1:0] cls;
        logic       isMul;
        logic       dp;
        logic       exec;
        logic       logical;
        logic       isSub;
        logic       extra;
        logic       cOld;
        logic       wr;
        logic       pcs;
        aluOp_t     op;
        word_t      p;
        word_t      q;
        word_t      b2;
        word_t      y;
        longint     ur;
        longint     sr;
        nzcv_t      aluF;
        nzcv_t      mask;
        nzcv_t      newF;
        cls     = ins[27:26];
        isMul   = cls == 2'b00 && !ins[25] && ins[7:4] == 4'b1001 && ins[24:21] == 4'b0000;
        dp      = cls == 2'b00 && !isMul;
        exec    = dp && condHolds(ins[31:28], modelFlg[lane]);
        op      = aluOp_t'(ins[24:21]);
        b2      = ins[25] ? expandImm(ins[11:0]) : curB;
        cOld    = modelFlg[lane][1];
        logical = op inside {ALU_AND, ALU_EOR, ALU_TST, ALU_TEQ,
                             ALU_ORR, ALU_MOV, ALU_BIC, ALU_MVN};
        p       = curA;
        q       = b2;
        isSub   = 1'b0;
        extra   = 1'b0;
        y       = '0;
        case (op)
            ALU_AND, ALU_TST: y = curA & b2;
            ALU_EOR, ALU_TEQ: y = curA ^ b2;
            ALU_ORR:          y = curA | b2;
            ALU_MOV:          y = b2;
            ALU_BIC:          y = curA & ~b2;
            ALU_MVN:          y = ~b2;
            ALU_SUB, ALU_CMP: isSub = 1'b1;
            ALU_SBC: begin
                isSub = 1'b1;
                extra = !cOld;    // Borrow in
            end
            ALU_RSB, ALU_RSC: begin
                p     = b2;
                q     = curA;
                isSub = 1'b1;
                extra = op == ALU_RSC && !cOld;
            end
            ALU_ADC: extra = cOld;
            default: extra = 1'b0;
        endcase
        if (isSub) begin
            ur = longint'(p) - longint'(q) - longint'(extra);
            sr = longint'($signed(p)) - longint'($signed(q)) - longint'(extra);
        end else begin
            ur = longint'(p) + longint'(q) + longint'(extra);
            sr = longint'($signed(p)) + longint'($signed(q)) + longint'(extra);
        end
        if (!logical) begin
            y = word_t'(ur);
        end
        aluF[3] = y[`DATA_WIDTH-1];
        aluF[2] = y == '0;
        aluF[1] = logical ? cOld : (isSub ? ur >= 0 : ur != longint'(y));
        aluF[0] = !logical && sr != longint'($signed(y));
        mask    = (exec && ins[20]) ? (logical ? 4'b1110 : 4'b1111) : 4'b0000;
        newF    = (modelFlg[lane] & ~mask) | (aluF & mask);
        wr      = exec && !(op inside {ALU_TST, ALU_TEQ, ALU_CMP, ALU_CMN});
        pcs     = cls == 2'b10 || (dp && ins[15:12] == 4'd15);
        if (wr) begin
            modelRes[lane] = y;
        end
        modelFlg[lane] = newF;
        expStat[lane]  = word_t'({modelRes[lane] == '0, exec, ins[15:12], cls, newF,
                                  mask != 4'b0000, pcs, wr, 1'b1});
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Bus access and checks
    ////////////////////////////////////////////////////////////////////////////
    task automatic checkValue(input word_t got, input word_t exp, input string what);
        assert (got == exp) else begin
            $display("MISMATCH at time %0t: %s is %h, expected %h", $time, what, got, exp);
            $display("TESTS FAILED");
            $fatal(1, "Wrong value from DUT");
        end
    endtask

    // Called on a falling edge, returns on one
    task automatic busCycle(input logic we, input logic [3:0] adr, input word_t dat,
                            output word_t rdat);
        int waited;
        waited = 0;
        wbCyc  = 1'b1;
        wbStb  = 1'b1;
        wbWe   = we;
        wbAdr  = adr;
        wbDatW = dat;
        @(negedge clk);
        while (!wbAck) begin
            assert (waited < ACK_LIMIT) else begin
                $display("No acknowledge from the DUT at address %0d within %0d cycles",
                         adr, ACK_LIMIT);
                $display("TESTS FAILED");
                $fatal(1, "Bus timeout");
            end
            waited++;
            @(negedge clk);
        end
        rdat  = wbDatR;
        wbCyc = 1'b0;
        wbStb = 1'b0;
        wbWe  = 1'b0;
    endtask

    task automatic wbWrite(input logic [3:0] adr, input word_t dat);
        word_t unused;
        busCycle(1'b1, adr, dat, unused);
    endtask

    task automatic wbRead(input logic [3:0] adr, output word_t dat);
        busCycle(1'b0, adr, '0, dat);
    endtask

    task automatic setOperands(input word_t a, input word_t b);
        curA = a;
        curB = b;
        wbWrite(4'd0, a);
        wbWrite(4'd1, b);
    endtask

    task automatic issueInstr(input int lane, input word_t ins);
        wbWrite(4'(2 + lane), ins);
        applyModel(lane, ins);
    endtask

    task automatic checkLane(input int lane);
        word_t got;
        wbRead(4'(8 + lane), got);
        checkValue(got, modelRes[lane], $sformatf("lane %0d result", lane));
        wbRead(4'(12 + lane), got);
        checkValue(got, expStat[lane], $sformatf("lane %0d status", lane));
        expStat[lane][0] = 1'b0;    // Cleared by the status read
    endtask

    task automatic runOne(input int lane, input word_t ins, input word_t a, input word_t b);
        setOperands(a, b);
        issueInstr(lane, ins);
        checkLane(lane);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////////////////////////////////////////
    task automatic testReset();
        word_t got;
        for (int i = 0; i < `NUM_LANES; i++) begin
            wbRead(4'(12 + i), got);
            checkValue(got, '0, $sformatf("lane %0d status after reset", i));
            wbRead(4'(8 + i), got);
            checkValue(got, '0, $sformatf("lane %0d result after reset", i));
        end
        wbRead(4'd6, got);
        checkValue(got, '0, "unmapped read");
        // Reset flags show in the status of a TST without S
        for (int i = 0; i < `NUM_LANES; i++) begin
            runOne(i, dpInstr(4'hE, ALU_TST, 1'b0, 1'b0, 4'd0, 12'h002),
                   $urandom, $urandom);
        end
    endtask

    task automatic testAlu();
        int lane;
        for (int op = 0; op < 16; op++) begin
            for (int form = 0; form < 2; form++) begin
                lane = $urandom_range(0, `NUM_LANES - 1);
                runOne(lane, dpInstr(4'hE, aluOp_t'(op), 1'b0, form == 1,
                                     4'($urandom_range(0, 15)),
                                     form == 1 ? 12'($urandom) : 12'h002),
                       $urandom, $urandom);
            end
        end
    endtask

    task automatic testFlags();
        int    lane;
        word_t a;
        for (int op = 0; op < 16; op++) begin
            for (int round = 0; round < 2; round++) begin
                lane = $urandom_range(0, `NUM_LANES - 1);
                a    = $urandom;
                // Equal operands first round, for Z and borrow cases
                runOne(lane, dpInstr(4'hE, aluOp_t'(op), 1'b1, 1'b0, 4'd3, 12'h002),
                       a, round == 0 ? a : $urandom);
            end
        end
        runOne(0, dpInstr(4'hE, ALU_ADD, 1'b1, 1'b0, 4'd3, 12'h002),
               32'h7FFF_FFFF, 32'h0000_0001);    // Signed overflow
    endtask

    task automatic testCond();
        int          lane;
        logic        imm;
        logic [11:0] op2;
        for (int n = 0; n < 30; n++) begin
            lane = $urandom_range(0, `NUM_LANES - 1);
            imm  = $urandom_range(0, 1) == 1;
            op2  = imm ? 12'($urandom) : 12'h002;
            runOne(lane, dpInstr(cond_t'($urandom_range(0, 14)), aluOp_t'($urandom_range(0, 15)),
                                 $urandom_range(0, 3) != 0, imm,
                                 4'($urandom_range(0, 14)), op2),
                   $urandom, $urandom);
        end
    endtask

    task automatic testLanes();
        word_t got;
        setOperands($urandom, $urandom);
        for (int i = 0; i < `NUM_LANES; i++) begin
            issueInstr(i, dpInstr(4'hE, aluOp_t'($urandom_range(0, 15)), 1'b1, 1'b0,
                                  4'(i), 12'h002));
        end
        for (int i = 0; i < `NUM_LANES; i++) begin
            checkLane(i);
        end
        for (int i = 0; i < `NUM_LANES; i++) begin
            wbRead(4'(12 + i), got);
            checkValue(got, expStat[i], $sformatf("lane %0d status with done cleared", i));
        end
        // Lane 0 gets Z, lane 1 not, then MOVEQ on both
        setOperands(32'h0000_0005, 32'h0000_0005);
        issueInstr(0, dpInstr(4'hE, ALU_CMP, 1'b1, 1'b0, 4'd0, 12'h002));
        issueInstr(1, dpInstr(4'hE, ALU_CMN, 1'b1, 1'b0, 4'd0, 12'h002));
        issueInstr(0, dpInstr(4'h0, ALU_MOV, 1'b0, 1'b1, 4'd5, 12'h0AB));
        issueInstr(1, dpInstr(4'h0, ALU_MOV, 1'b0, 1'b1, 4'd5, 12'h0AB));
        checkLane(0);
        checkLane(1);
    endtask

    task automatic testClasses();
        runOne(2, dpInstr(4'hE, ALU_SUB, 1'b1, 1'b0, 4'd7, 12'h002),
               32'h0000_0010, 32'h0000_0020);    // Negative result, known flags
        issueInstr(2, 32'hEA00_0010);            // B
        checkLane(2);
        issueInstr(2, 32'hE591_3004);            // LDR
        checkLane(2);
        issueInstr(2, 32'hE581_2000);            // STR
        checkLane(2);
        issueInstr(2, 32'hE7F0_4FF1);            // Divide encoding
        checkLane(2);
        issueInstr(2, 32'hEE01_5A10);            // Float
        checkLane(2);
        issueInstr(2, 32'hE000_0291);            // MUL
        checkLane(2);
        issueInstr(2, dpInstr(4'hE, ALU_ADD, 1'b0, 1'b0, 4'd15, 12'h002));
        checkLane(2);
    endtask

    // Watchdog
    initial begin
        #(BUS_OPS * CYCLES_PER_OP * PERIOD);
        $display("Watchdog expired before the tests completed");
        $display("TESTS FAILED");
        $fatal(1, "Timeout");
    end

    initial begin
        void'($urandom(11440));
        rstN   = 1'b0;
        wbCyc  = 1'b0;
        wbStb  = 1'b0;
        wbWe   = 1'b0;
        wbAdr  = 4'd0;
        wbDatW = '0;
        curA   = '0;
        curB   = '0;
        for (int i = 0; i < `NUM_LANES; i++) begin
            modelRes[i] = '0;
            modelFlg[i] = '0;
            expStat[i]  = '0;
        end
        repeat (3) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;

        testReset();
        testAlu();
        testFlags();
        testCond();
        testLanes();
        testClasses();

        $display("TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- dpCluster.f
+incdir+include
design/dpCluster_pkg.sv
design/controlUnit.sv
design/aluCore.sv
design/execLane.sv
design/issueDispatcher.sv
design/resultCollector.sv
design/dpCluster.sv
testbench/clockGen.sv
testbench/dpCluster_sva.sv
testbench/dpCluster_tb.sv

//--- Makefile
# Verilator build and run of the dpCluster testbench

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module dpCluster_tb -f dpCluster.f
	@out="$$(./obj_dir/VdpCluster_tb)"; echo "$$out"; echo "$$out" | grep -qx "TESTS PASSED"

clean:
	rm -rf obj_dir
